/* include/cache_cfg.svh */
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// bank select is addr[3:2], line index addr[6:4].
`define CACHE_BANKS    4
`define LINES_PER_BANK 8

// request window 0x0a00 to 0x0aff.
`define ADDR_BASE      32'h0000_0a00
`define ADDR_WORDS     64

`define REQ_PERIOD     10
`define HIST_DEPTH     8
`define GEN_SEED       32'h6b1d_3a57

`endif

/* rtl/cache_pkg.sv */
package cache_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // AHB-lite encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } ahb_trans_e;

    typedef enum logic [2:0] {
        SINGLE = 3'b000,  // only one used here.
        INCR   = 3'b001,
        WRAP4  = 3'b010,
        INCR4  = 3'b011,
        WRAP8  = 3'b100,
        INCR8  = 3'b101,
        WRAP16 = 3'b110,
        INCR16 = 3'b111
    } ahb_burst_e;

    typedef struct packed {
        logic [31:0] haddr;
        ahb_trans_e  htrans;
        ahb_burst_e  hburst;
        logic        hwrite;
    } ahb_req_t;

    typedef struct packed {
        logic [31:0] hrdata;
        logic        hready;
        logic        hresp;   // not checked.
    } ahb_rsp_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // internal links
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } cpu_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [31:0] data;
        logic        hit;
    } cpu_rsp_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } fetch_req_t;

    typedef enum logic [1:0] {IDLE_S, LOOKUP_S, FETCH_S, RESP_S} bank_state_e;

    // merge side sequencer for one memory read.
    typedef enum logic [1:0] {F_IDLE, F_ADDR, F_DATA, F_DONE} fetch_state_e;

endpackage

/* rtl/cpu_req_gen.sv */
`timescale 1ns/1ns
`include "cache_cfg.svh"

module cpu_req_gen (
    input  logic                cpu_intf,
    input  logic                rst_n,
    output cache_pkg::cpu_req_t req,
    input  logic                req_ready
);

    localparam int CNT_W  = $clog2(`REQ_PERIOD);
    localparam int HIST_W = $clog2(`HIST_DEPTH);
    localparam int WORD_W = $clog2(`ADDR_WORDS);

    logic [31:0]             lfsr;
    logic                    lfsr_fb;
    logic [CNT_W-1:0]        cnt;
    logic                    req_vld;
    logic [31:0]             req_addr;
    logic                    launch;
    logic                    reuse;
    logic [HIST_W-1:0]       pick;
    logic [WORD_W-1:0]       fresh_word;
    logic [31:0]             fresh_addr;
    logic [31:0]             hist [`HIST_DEPTH];
    logic [`HIST_DEPTH-1:0]  hist_vld;
    logic [HIST_W-1:0]       wr_ptr;

    // taps 32,22,2,1.
    assign lfsr_fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];

    always_ff @(posedge cpu_intf or negedge rst_n) begin
        if (!rst_n) begin
            lfsr <= `GEN_SEED;
        end else begin
            lfsr <= {lfsr[30:0], lfsr_fb};
        end
    end

    assign launch     = !req_vld && (cnt == CNT_W'(`REQ_PERIOD - 1));
    assign pick       = lfsr[8 +: HIST_W];
    assign fresh_word = lfsr[16 +: WORD_W];
    assign fresh_addr = `ADDR_BASE + {{(30 - WORD_W){1'b0}}, fresh_word, 2'b00};
    assign reuse      = lfsr[0] && hist_vld[pick];  // empty history forces fresh.

    // period counter stalls while a request waits.
    always_ff @(posedge cpu_intf or negedge rst_n) begin
        if (!rst_n) begin
            req_vld  <= 1'b0;
            cnt      <= '0;
            wr_ptr   <= '0;
            hist_vld <= '0;
        end else if (req_vld) begin
            if (req_ready) begin
                req_vld <= 1'b0;
                cnt     <= '0;
            end
        end else if (launch) begin
            req_vld <= 1'b1;
            if (!reuse) begin
                hist_vld[wr_ptr] <= 1'b1;
                wr_ptr <= (wr_ptr == HIST_W'(`HIST_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge cpu_intf) begin
        if (launch) begin
            req_addr <= reuse ? hist[pick] : fresh_addr;
            if (!reuse) begin
                hist[wr_ptr] <= fresh_addr;
            end
        end
    end

    assign req = '{valid: req_vld, addr: req_addr};

endmodule

/* rtl/bank_dispatch.sv */
`timescale 1ns/1ns
`include "cache_cfg.svh"

module bank_dispatch (
    input  cache_pkg::cpu_req_t       req,
    output logic                      req_ready,
    output cache_pkg::cpu_req_t       bank_req [`CACHE_BANKS],
    input  logic [`CACHE_BANKS-1:0]   bank_ready
);

    localparam int BANK_W = $clog2(`CACHE_BANKS);

    logic [BANK_W-1:0] sel;

    assign sel = req.addr[2 +: BANK_W];  // word interleave.

    always_comb begin
        for (int b = 0; b < `CACHE_BANKS; b++) begin
            bank_req[b].valid = req.valid && (sel == BANK_W'(b));
            bank_req[b].addr  = req.addr;
        end
    end

    // only the addressed bank can stall the source.
    assign req_ready = bank_ready[sel];

endmodule

/* rtl/cache_bank.sv */
`timescale 1ns/1ns
`include "cache_cfg.svh"

module cache_bank (
    input  logic                  cpu_intf,
    input  logic                  rst_n,
    input  cache_pkg::cpu_req_t   req,
    output logic                  req_ready,
    output cache_pkg::fetch_req_t fetch,
    input  logic                  fetch_ready,
    input  logic                  fetch_done,
    input  logic [31:0]           fetch_data,
    output cache_pkg::cpu_rsp_t   rsp,
    input  logic                  rsp_ready
);

    localparam int BANK_W  = $clog2(`CACHE_BANKS);
    localparam int LINE_W  = $clog2(`LINES_PER_BANK);
    localparam int IDX_LSB = 2 + BANK_W;
    localparam int TAG_LSB = IDX_LSB + LINE_W;
    localparam int TAG_W   = 32 - TAG_LSB;

    cache_pkg::bank_state_e      state;
    logic [31:0]                 cur_addr;
    logic [LINE_W-1:0]           line_idx;
    logic [TAG_W-1:0]            line_tag;
    logic                        look_hit;
    logic                        fetch_vld;
    logic                        rsp_vld;
    logic [31:0]                 rsp_data;
    logic                        rsp_hit;
    logic [`LINES_PER_BANK-1:0]  line_vld;
    logic [TAG_W-1:0]            tag_mem  [`LINES_PER_BANK];
    logic [31:0]                 data_mem [`LINES_PER_BANK];

    assign line_idx  = cur_addr[IDX_LSB +: LINE_W];
    assign line_tag  = cur_addr[31:TAG_LSB];
    assign look_hit  = line_vld[line_idx] && (tag_mem[line_idx] == line_tag);
    assign req_ready = (state == cache_pkg::IDLE_S);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge cpu_intf or negedge rst_n) begin
        if (!rst_n) begin
            state     <= cache_pkg::IDLE_S;
            fetch_vld <= 1'b0;
            rsp_vld   <= 1'b0;
            line_vld  <= '0;
        end else begin
            case (state)
                cache_pkg::IDLE_S: begin
                    if (req.valid) state <= cache_pkg::LOOKUP_S;
                end
                cache_pkg::LOOKUP_S: begin
                    if (look_hit) begin
                        state <= cache_pkg::RESP_S;
                    end else begin
                        state     <= cache_pkg::FETCH_S;
                        fetch_vld <= 1'b1;
                    end
                end
                cache_pkg::FETCH_S: begin
                    if (fetch_vld && fetch_ready) fetch_vld <= 1'b0;
                    if (fetch_done) begin
                        line_vld[line_idx] <= 1'b1;  // line filled.
                        state <= cache_pkg::RESP_S;
                    end
                end
                cache_pkg::RESP_S: begin
                    if (!rsp_vld) begin
                        rsp_vld <= 1'b1;  // response register stage.
                    end else if (rsp_ready) begin
                        rsp_vld <= 1'b0;
                        state   <= cache_pkg::IDLE_S;
                    end
                end
                default: state <= cache_pkg::IDLE_S;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stores and payload
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge cpu_intf) begin
        if (req.valid && req_ready) cur_addr <= req.addr;
        if (state == cache_pkg::LOOKUP_S) begin
            rsp_data <= data_mem[line_idx];
            rsp_hit  <= look_hit;  // stays clear on a miss.
        end else if (state == cache_pkg::FETCH_S && fetch_done) begin
            rsp_data           <= fetch_data;
            data_mem[line_idx] <= fetch_data;
            tag_mem[line_idx]  <= line_tag;
        end
    end

    assign fetch = '{valid: fetch_vld, addr: cur_addr};
    assign rsp   = '{valid: rsp_vld, addr: cur_addr, data: rsp_data, hit: rsp_hit};

endmodule

/* rtl/bank_merge.sv */
`timescale 1ns/1ns
`include "cache_cfg.svh"

module bank_merge (
    input  logic                    cpu_intf,
    input  logic                    rst_n,
    input  cache_pkg::fetch_req_t   fetch [`CACHE_BANKS],
    output logic [`CACHE_BANKS-1:0] fetch_ready,
    output logic [`CACHE_BANKS-1:0] fetch_done,
    output logic [31:0]             fetch_data,
    output cache_pkg::ahb_req_t     ahb_req,
    input  cache_pkg::ahb_rsp_t     ahb_rsp,
    input  cache_pkg::cpu_rsp_t     bank_rsp [`CACHE_BANKS],
    output logic [`CACHE_BANKS-1:0] bank_rsp_ready,
    output cache_pkg::cpu_rsp_t     rsp,
    input  logic                    rsp_ready
);

    localparam int BANK_W = $clog2(`CACHE_BANKS);

    cache_pkg::fetch_state_e  f_state;
    logic [`CACHE_BANKS-1:0]  f_vld_vec;
    logic [`CACHE_BANKS-1:0]  r_vld_vec;
    logic [BANK_W-1:0]        f_ptr;
    logic [BANK_W-1:0]        r_ptr;
    logic [BANK_W-1:0]        f_gnt;
    logic [BANK_W-1:0]        r_gnt;
    logic [BANK_W-1:0]        f_sel;
    logic [31:0]              f_addr;
    logic                     r_load;
    logic                     out_vld;
    cache_pkg::cpu_rsp_t      out_rsp;

    // first requester at or after the pointer.
    function automatic logic [BANK_W-1:0] rr_pick(input logic [`CACHE_BANKS-1:0] vld,
                                                  input logic [BANK_W-1:0] ptr);
        logic [BANK_W-1:0] cand;
        logic              found;
        rr_pick = ptr;
        found   = 1'b0;
        for (int i = 0; i < `CACHE_BANKS; i++) begin
            cand = ptr + BANK_W'(i);
            if (!found && vld[cand]) begin
                rr_pick = cand;
                found   = 1'b1;
            end
        end
    endfunction

    always_comb begin
        for (int b = 0; b < `CACHE_BANKS; b++) begin
            f_vld_vec[b] = fetch[b].valid;
            r_vld_vec[b] = bank_rsp[b].valid;
        end
    end

    assign f_gnt  = rr_pick(f_vld_vec, f_ptr);
    assign r_gnt  = rr_pick(r_vld_vec, r_ptr);
    assign r_load = (|r_vld_vec) && (!out_vld || rsp_ready);

    always_comb begin
        for (int b = 0; b < `CACHE_BANKS; b++) begin
            fetch_ready[b]    = (f_state == cache_pkg::F_IDLE) && (|f_vld_vec)
                                && (f_gnt == BANK_W'(b));
            fetch_done[b]     = (f_state == cache_pkg::F_DONE) && (f_sel == BANK_W'(b));
            bank_rsp_ready[b] = r_load && (r_gnt == BANK_W'(b));
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // AHB read sequencer, one transfer outstanding
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge cpu_intf or negedge rst_n) begin
        if (!rst_n) begin
            f_state <= cache_pkg::F_IDLE;
            f_ptr   <= '0;
            r_ptr   <= '0;
            out_vld <= 1'b0;
        end else begin
            case (f_state)
                cache_pkg::F_IDLE: if (|f_vld_vec) begin
                    f_state <= cache_pkg::F_ADDR;
                    f_ptr   <= f_gnt + 1'b1;
                end
                cache_pkg::F_ADDR: if (ahb_rsp.hready) f_state <= cache_pkg::F_DATA;
                cache_pkg::F_DATA: if (ahb_rsp.hready) f_state <= cache_pkg::F_DONE;
                default:           f_state <= cache_pkg::F_IDLE;  // done pulse.
            endcase
            if (r_load) begin
                out_vld <= 1'b1;
                r_ptr   <= r_gnt + 1'b1;
            end else if (rsp_ready) begin
                out_vld <= 1'b0;
            end
        end
    end

    always_ff @(posedge cpu_intf) begin
        if (f_state == cache_pkg::F_IDLE && (|f_vld_vec)) begin
            f_sel  <= f_gnt;
            f_addr <= fetch[f_gnt].addr;
        end
        if (f_state == cache_pkg::F_DATA && ahb_rsp.hready) fetch_data <= ahb_rsp.hrdata;
        if (r_load) out_rsp <= bank_rsp[r_gnt];
    end

    assign ahb_req = '{haddr:  f_addr,
                       htrans: (f_state == cache_pkg::F_ADDR) ? cache_pkg::NONSEQ
                                                              : cache_pkg::IDLE,
                       hburst: cache_pkg::SINGLE,
                       hwrite: 1'b0};

    assign rsp = '{valid: out_vld, addr: out_rsp.addr, data: out_rsp.data, hit: out_rsp.hit};

endmodule

/* rtl/cache_top.sv */
`timescale 1ns/1ns
`include "cache_cfg.svh"

module cache_top (
    input  logic                cpu_intf,
    input  logic                rst_n,
    output cache_pkg::ahb_req_t ahb_req,
    input  cache_pkg::ahb_rsp_t ahb_rsp,
    output cache_pkg::cpu_rsp_t rsp,
    input  logic                rsp_ready,
    output cache_pkg::cpu_req_t req_mon,
    output logic                req_fire
);

    cache_pkg::cpu_req_t      gen_req;
    logic                     gen_ready;
    cache_pkg::cpu_req_t      bank_req [`CACHE_BANKS];
    logic [`CACHE_BANKS-1:0]  bank_ready;
    cache_pkg::fetch_req_t    fetch [`CACHE_BANKS];
    logic [`CACHE_BANKS-1:0]  fetch_ready;
    logic [`CACHE_BANKS-1:0]  fetch_done;
    logic [31:0]              fetch_data;
    cache_pkg::cpu_rsp_t      bank_rsp [`CACHE_BANKS];
    logic [`CACHE_BANKS-1:0]  bank_rsp_ready;

    cpu_req_gen u_gen (
        .cpu_intf  (cpu_intf),
        .rst_n     (rst_n),
        .req       (gen_req),
        .req_ready (gen_ready)
    );

    bank_dispatch u_dispatch (
        .req        (gen_req),
        .req_ready  (gen_ready),
        .bank_req   (bank_req),
        .bank_ready (bank_ready)
    );

    for (genvar g = 0; g < `CACHE_BANKS; g++) begin : g_bank
        cache_bank u_bank (
            .cpu_intf    (cpu_intf),
            .rst_n       (rst_n),
            .req         (bank_req[g]),
            .req_ready   (bank_ready[g]),
            .fetch       (fetch[g]),
            .fetch_ready (fetch_ready[g]),
            .fetch_done  (fetch_done[g]),
            .fetch_data  (fetch_data),
            .rsp         (bank_rsp[g]),
            .rsp_ready   (bank_rsp_ready[g])
        );
    end

    bank_merge u_merge (
        .cpu_intf       (cpu_intf),
        .rst_n          (rst_n),
        .fetch          (fetch),
        .fetch_ready    (fetch_ready),
        .fetch_done     (fetch_done),
        .fetch_data     (fetch_data),
        .ahb_req        (ahb_req),
        .ahb_rsp        (ahb_rsp),
        .bank_rsp       (bank_rsp),
        .bank_rsp_ready (bank_rsp_ready),
        .rsp            (rsp),
        .rsp_ready      (rsp_ready)
    );

    assign req_mon  = gen_req;
    assign req_fire = gen_req.valid && gen_ready;  // accepted request.

endmodule

/* bench/ahb_mem_model.sv */
`timescale 1ns/1ns

module ahb_mem_model (
    input  logic                cpu_intf,
    input  logic                rst_n,
    input  cache_pkg::ahb_req_t ahb_req,
    output cache_pkg::ahb_rsp_t ahb_rsp,
    input  logic [1:0]          wait_cycles
);

    logic        busy;
    logic [1:0]  cnt;
    logic [31:0] addr;
    logic        ready;
    logic        start;

    assign ready = !busy || (cnt == 2'd0);
    assign start = ready && (ahb_req.htrans == cache_pkg::NONSEQ);

    always_ff @(posedge cpu_intf or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (start) begin
            busy <= 1'b1;  // data phase begins.
            cnt  <= wait_cycles;
        end else if (busy) begin
            if (cnt == 2'd0) begin
                busy <= 1'b0;
            end else begin
                cnt <= cnt - 2'd1;
            end
        end
    end

    always_ff @(posedge cpu_intf) begin
        if (start) addr <= ahb_req.haddr;
    end

    assign ahb_rsp = '{hrdata: busy ? (addr ^ 32'h5a5a_0000) : 32'h0,
                       hready: ready,
                       hresp:  1'b0};

endmodule

/* bench/cache_tb.sv */
`timescale 1ns/1ns
`include "cache_cfg.svh"

module cache_tb;

    localparam int NUM_REQS      = 200;
    localparam int REQ_TIMEOUT   = 20000;
    localparam int DRAIN_TIMEOUT = 2000;

    logic                cpu_intf;
    logic                rst_n;
    logic                rsp_ready;
    logic [1:0]          mem_wait;
    cache_pkg::ahb_req_t ahb_req;
    cache_pkg::ahb_rsp_t ahb_rsp;
    cache_pkg::cpu_rsp_t rsp;
    cache_pkg::cpu_req_t req_mon;
    logic                req_fire;

    logic [31:0] rng = 32'h1e28542a;
    int          pending [`ADDR_WORDS];
    logic [31:0] recent [`HIST_DEPTH];
    bit          recent_vld [`HIST_DEPTH];
    int          recent_ptr;
    bit          line_vld [`CACHE_BANKS][`LINES_PER_BANK];
    logic [24:0] line_tag [`CACHE_BANKS][`LINES_PER_BANK];
    int          req_count, rsp_count, miss_count, xfer_count, outstanding, reused, fresh;
    int          err_reset, err_req, err_rsp, err_ahb, err_count, err_other;

    cache_top DUT (
        .cpu_intf  (cpu_intf),
        .rst_n     (rst_n),
        .ahb_req   (ahb_req),
        .ahb_rsp   (ahb_rsp),
        .rsp       (rsp),
        .rsp_ready (rsp_ready),
        .req_mon   (req_mon),
        .req_fire  (req_fire)
    );

    ahb_mem_model u_mem (
        .cpu_intf    (cpu_intf),
        .rst_n       (rst_n),
        .ahb_req     (ahb_req),
        .ahb_rsp     (ahb_rsp),
        .wait_cycles (mem_wait)
    );

    initial begin
        cpu_intf = 1'b0;
        forever #20 cpu_intf = ~cpu_intf;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            rng = {rng[30:0], rng[31] ^ rng[21] ^ rng[1] ^ rng[0]};  // one step per bit.
            r   = {r[30:0], rng[0]};
        end
        return r;
    endfunction

    function automatic bit in_window(input logic [31:0] a);
        return (a[1:0] == 2'b00) && (a >= `ADDR_BASE) && (a < `ADDR_BASE + 4 * `ADDR_WORDS);
    endfunction

    function automatic int word_index(input logic [31:0] a);
        return int'((a - `ADDR_BASE) >> 2);
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return a ^ 32'h5a5a_0000;
    endfunction

    task automatic compare_rsp(input cache_pkg::cpu_rsp_t act, input cache_pkg::cpu_rsp_t exp,
                               input string what);
        if (act !== exp) begin
            err_rsp++;
            $display("FAIL %0t: %s got addr %h data %h hit %b, expected addr %h data %h hit %b",
                     $time, what, act.addr, act.data, act.hit, exp.addr, exp.data, exp.hit);
        end
    endtask

    task automatic compare_ahb(input cache_pkg::ahb_req_t act, input cache_pkg::ahb_req_t exp,
                               input string what);
        if (act !== exp) begin
            err_ahb++;
            $display("FAIL %0t: %s got htrans %b hburst %b hwrite %b, expected %b %b %b",
                     $time, what, act.htrans, act.hburst, act.hwrite,
                     exp.htrans, exp.hburst, exp.hwrite);
        end
    endtask

    task automatic compare_count(input int act, input int exp, input string what);
        if (act != exp) begin
            err_count++;
            $display("FAIL %0t: %s is %0d, expected %0d", $time, what, act, exp);
        end
    endtask

    task automatic expect_idle(input string when);
        if (ahb_req.htrans !== cache_pkg::IDLE || rsp.valid !== 1'b0 || req_fire !== 1'b0) begin
            err_reset++;
            $display("FAIL %0t: outputs not idle %s (htrans %b, rsp valid %b, req_fire %b)",
                     $time, when, ahb_req.htrans, rsp.valid, req_fire);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic note_request(input logic [31:0] a);
        int w;
        bit in_hist;
        req_count++;
        if (!in_window(a)) begin
            err_req++;
            $display("FAIL %0t: request addr %h outside window or unaligned", $time, a);
        end else begin
            w       = word_index(a);
            in_hist = 1'b0;
            for (int i = 0; i < `HIST_DEPTH; i++) begin
                if (recent_vld[i] && recent[i] == a) in_hist = 1'b1;
            end
            if (in_hist) begin
                reused++;  // one of the last few fresh addresses.
            end else begin
                fresh++;
                recent[recent_ptr]     = a;
                recent_vld[recent_ptr] = 1'b1;
                recent_ptr             = (recent_ptr + 1) % `HIST_DEPTH;
            end
            pending[w]++;
            outstanding++;
        end
    endtask

    task automatic score_response(input cache_pkg::cpu_rsp_t act);
        cache_pkg::cpu_rsp_t exp;
        int                  w;
        int                  b;
        int                  l;
        if (!in_window(act.addr)) begin
            err_rsp++;
            $display("FAIL %0t: response addr %h outside window", $time, act.addr);
            return;
        end
        w   = word_index(act.addr);
        b   = act.addr[3:2];
        l   = act.addr[6:4];
        exp = '{valid: 1'b1, addr: act.addr, data: mem_word(act.addr),
                hit: line_vld[b][l] && (line_tag[b][l] == act.addr[31:7])};
        compare_rsp(act, exp, "read response");
        if (pending[w] == 0) begin
            err_rsp++;
            $display("FAIL %0t: response for %h has no pending request", $time, act.addr);
        end else begin
            pending[w]--;
            outstanding--;
        end
        rsp_count++;
        if (act.hit === 1'b0) miss_count++;
        line_vld[b][l] = 1'b1;  // filled after a miss.
        line_tag[b][l] = act.addr[31:7];
    endtask

    task automatic score_transfer(input cache_pkg::ahb_req_t act);
        cache_pkg::ahb_req_t exp;
        exp = '{haddr: act.haddr, htrans: cache_pkg::NONSEQ, hburst: cache_pkg::SINGLE,
                hwrite: 1'b0};
        compare_ahb(act, exp, "memory transfer");
        if (!in_window(act.haddr) || pending[word_index(act.haddr)] == 0) begin
            err_ahb++;
            $display("FAIL %0t: memory read of %h with no pending request", $time, act.haddr);
        end
        xfer_count++;
    endtask

    // mid-cycle sampling; each event transfers at the next rising edge.
    always @(negedge cpu_intf) begin
        if (rst_n) begin
            if (req_fire) note_request(req_mon.addr);
            if (rsp.valid && rsp_ready) score_response(rsp);
            if (ahb_req.htrans != cache_pkg::IDLE && ahb_rsp.hready) score_transfer(ahb_req);
        end
    end

    always @(posedge cpu_intf) begin
        #5;
        rsp_ready = (take_bits(2) != 32'd0);  // low about one cycle in four.
        mem_wait  = 2'(take_bits(2));
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int cycles;
        int errors;
        rst_n     = 1'b0;
        rsp_ready = 1'b0;
        mem_wait  = 2'd0;
        repeat (2) begin
            @(negedge cpu_intf);
            expect_idle("during reset");
        end
        @(posedge cpu_intf);
        #5;
        rst_n = 1'b1;  // three edges in reset.
        @(negedge cpu_intf);
        expect_idle("on the first cycle after reset");

        cycles = 0;
        while (req_count < NUM_REQS && cycles < REQ_TIMEOUT) begin
            @(posedge cpu_intf);
            cycles++;
        end
        if (req_count < NUM_REQS) begin
            err_other++;
            $display("timeout: only %0d of %0d requests were accepted", req_count, NUM_REQS);
        end else begin
            cycles = 0;
            while (outstanding != 0 && cycles < DRAIN_TIMEOUT) begin
                @(posedge cpu_intf);
                cycles++;
            end
            if (outstanding != 0) begin
                err_other++;
                $display("timeout: %0d requests never got a response", outstanding);
            end
        end

        compare_count(xfer_count, miss_count, "memory transfers against misses");
        compare_count(rsp_count, req_count, "responses against requests");
        for (int w = 0; w < `ADDR_WORDS; w++) begin
            compare_count(pending[w], 0, $sformatf("pending count of word %0d", w));
        end
        // plain random picks would rarely repeat a recent address.
        if (4 * reused < req_count || 4 * fresh < req_count) begin
            err_req++;
            $display("FAIL %0t: request stream has %0d reused and %0d fresh addresses",
                     $time, reused, fresh);
        end

        errors = err_reset + err_req + err_rsp + err_ahb + err_count + err_other;
        $display("errors: reset %0d, request %0d, response %0d, ahb %0d, count %0d, other %0d",
                 err_reset, err_req, err_rsp, err_ahb, err_count, err_other);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+include
rtl/cache_pkg.sv
rtl/cpu_req_gen.sv
rtl/bank_dispatch.sv
rtl/cache_bank.sv
rtl/bank_merge.sv
rtl/cache_top.sv
bench/ahb_mem_model.sv
bench/cache_tb.sv

/* Bender.yml */
package:
  name: cache_subsys

export_include_dirs:
  - include

sources:
  - rtl/cache_pkg.sv
  - rtl/cpu_req_gen.sv
  - rtl/bank_dispatch.sv
  - rtl/cache_bank.sv
  - rtl/bank_merge.sv
  - rtl/cache_top.sv
  - target: test
    files:
      - bench/ahb_mem_model.sv
      - bench/cache_tb.sv
